// File: flist.f
+incdir+include
hdl/msx_bus_pkg.sv
hdl/cart_pkg.sv
hdl/cart_ctrl.sv
hdl/cart_ascii8.sv
hdl/cart_ascii16.sv
hdl/cart_top.sv
test/cart_tb.sv

// File: Makefile
# Verilator build and run of the cartridge slot testbench
SRCS := $(shell grep -v '^+' flist.f) include/cart_cfg.svh

.PHONY: all run clean

all: run

obj_dir/Vcart_tb: flist.f $(SRCS)
	verilator --binary --assert --timing --top-module cart_tb -f flist.f -o Vcart_tb

# The run passes only when the pass line shows up in the simulator output
run: obj_dir/Vcart_tb
	@out="$$(./obj_dir/Vcart_tb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q -F '=== PASS ==='

clean:
	rm -rf obj_dir

// File: test/cart_tb.sv
/* Testbench for cart_top with a reference model of both mappers. The port named
   reset carries the clock and clk is the reset; the ROM is fixed at 512 kB */
`timescale 1ns/1ns
`default_nettype none
`include "cart_cfg.svh"

module cart_tb;
    import cart_pkg::*;

    logic         reset;
    logic         clk;
    logic [15:0]  addr;
    logic [7:0]   d_from_cpu;
    logic         wr;
    logic         cs;
    mapper_kind_t mapper_kind;
    rom_addr_t    rom_size;
    sram_size_t   sram_size;
    rom_addr_t    mem_addr;
    logic         mem_oe;
    sram_addr_t   sram_addr;
    logic         sram_oe;
    logic         sram_we;

    // Reference copies of the bank registers and SRAM page enables
    bank_t        m8_rom [0:3];
    bank_t        m8_sram [0:7];
    logic [7:0]   m8_en;
    bank_t        m16_rom [0:1];
    logic [1:0]   m16_en;
    bank_t        en_bit;
    logic [2:0]   wr_page;
    logic [2:0]   pg;
    rom_addr_t    exp_mem_addr;
    sram_addr_t   exp_sram_addr;
    logic         exp_sram_oe;
    logic [31:0]  lfsr = 32'h9cac6625;
    logic         seen_we = 1'b0;

    cart_top uut (.*);

    initial begin
        reset = 1'b0;
        forever #10 reset = ~reset;
    end

    // ROM size in 8 kB units is the ASCII8 SRAM enable bit, except on Wizardry
    assign en_bit  = (mapper_kind == kind_wizardry) ? 8'h80 : rom_size[20:13];
    assign wr_page = {1'b0, addr[12:11]} + 3'd2;
    assign pg      = addr[15:13];

    always @(posedge reset or posedge clk) begin
        if (clk) begin
            m8_rom  <= '{default: '0};
            m8_sram <= '{default: '0};
            m8_en   <= '0;
            m16_rom <= '{default: '0};
            m16_en  <= '0;
        end else if (cs && wr && addr[15:13] == 3'b011) begin
            if (mapper_kind != kind_ascii16) begin
                if ((d_from_cpu & en_bit) != 8'h00) begin
                    m8_sram[wr_page] <= d_from_cpu & ~en_bit;
                    // Pages 4 and 5 always take SRAM, page 2 only on Koei
                    if (addr[12] || (addr[12:11] == 2'b00 && mapper_kind == kind_koei)) begin
                        m8_en[wr_page] <= 1'b1;
                    end
                end else begin
                    m8_en[wr_page]      <= 1'b0;
                    m8_rom[addr[12:11]] <= d_from_cpu;
                end
            end else if (!addr[11]) begin
                if (d_from_cpu == rom_size[21:14]) begin
                    m16_en[addr[12]] <= 1'b1;
                end else begin
                    m16_en[addr[12]]  <= 1'b0;
                    m16_rom[addr[12]] <= d_from_cpu;
                end
            end
        end
    end

    always_comb begin
        if (mapper_kind == kind_ascii16) begin
            // 16 kB pages 0 and 2 use bank 1, pages 1 and 3 use bank 0
            exp_mem_addr  = {3'b000, m16_rom[~addr[14]] & (rom_size[21:14] - 8'd1), addr[13:0]};
            exp_sram_oe   = cs && (addr[15] != addr[14]) && m16_en[~addr[14]];
            exp_sram_addr = {4'h0, addr[10:0]};
        end else begin
            exp_mem_addr  = {4'h0, m8_rom[pg[1:0] + 2'd2] & (rom_size[20:13] - 8'd1), addr[12:0]};
            exp_sram_oe   = cs && m8_en[pg];
            exp_sram_addr = {m8_sram[pg][1:0], addr[12:0]};
        end
        if (sram_size == `CART_SRAM_NONE) begin
            exp_sram_oe = 1'b0;
        end
        exp_sram_addr = exp_sram_addr & ((sram_size == 2'd0) ? 15'd2047 :
                                         (sram_size == 2'd1) ? 15'd8191 : 15'd32767);
    end

    always @(negedge reset) begin
        if (sram_we) begin
            seen_we <= 1'b1;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "output check failed");
    endtask

    task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d, input logic w);
        @(posedge reset);
        addr       <= a;
        d_from_cpu <= d;
        wr         <= w;
        cs         <= 1'b1;
    endtask

    task automatic set_config(input mapper_kind_t k, input sram_size_t s);
        @(posedge reset);
        cs          <= 1'b0;
        wr          <= 1'b0;
        mapper_kind <= k;
        sram_size   <= s;
    endtask

    // One read at a random offset in each 8 kB window, mirrors included
    task automatic read_windows();
        logic [15:0] r;
        for (int w = 0; w < 8; w++) begin
            take_bits(13, r);
            bus_cycle({w[2:0], r[12:0]}, 8'h00, 1'b0);
        end
    endtask

    task automatic write_banks(input logic [7:0] keep_out);
        logic [15:0] r;
        for (int g = 0; g < 4; g++) begin
            take_bits(8, r);
            bus_cycle({3'b011, g[1:0], 11'h000}, r[7:0] & ~keep_out, 1'b1);
        end
    endtask

    task automatic wait_sram_oe(input logic [15:0] a);
        int n;
        bus_cycle(a, 8'h00, 1'b0);
        n = 0;
        @(negedge reset);
        while (!sram_oe && n < 8) begin
            @(negedge reset);
            n++;
        end
        if (!sram_oe) begin
            $display("Timeout waiting for sram_oe at address %h", a);
            $display("=== FAIL ===");
            $fatal(1, "sram_oe timeout");
        end
    endtask

    task automatic sram_sequence(input mapper_kind_t k, input logic [7:0] eb,
                                 input sram_size_t s);
        logic [15:0] r;
        set_config(k, s);
        for (int g = 0; g < 4; g++) begin
            take_bits(8, r);
            // Bit 0 of every SRAM bank is set, which a narrower SRAM must mask off
            bus_cycle({3'b011, g[1:0], 11'h000}, eb | 8'h01 | (r[7:0] & ~eb), 1'b1);
        end
        read_windows();
        wait_sram_oe(16'h8123);
        bus_cycle(16'hb456, 8'h3c, 1'b1);
        bus_cycle(16'h4789, 8'hc3, 1'b1);
        // ROM writes to the same registers close the SRAM pages again
        write_banks(eb);
        read_windows();
    endtask

    a_mem_addr: assert property (@(posedge reset) disable iff (clk)
        cs |-> mem_addr == exp_mem_addr)
        else mismatch("mem_addr", 32'($sampled(mem_addr)), 32'($sampled(exp_mem_addr)));
    a_mem_oe: assert property (@(posedge reset) disable iff (clk) mem_oe == cs)
        else mismatch("mem_oe", 32'($sampled(mem_oe)), 32'($sampled(cs)));
    a_sram_oe: assert property (@(posedge reset) disable iff (clk) sram_oe == exp_sram_oe)
        else mismatch("sram_oe", 32'($sampled(sram_oe)), 32'($sampled(exp_sram_oe)));
    a_sram_we: assert property (@(posedge reset) disable iff (clk)
        sram_we == (exp_sram_oe && wr))
        else mismatch("sram_we", 32'($sampled(sram_we)), 32'($sampled(exp_sram_oe && wr)));
    a_sram_addr: assert property (@(posedge reset) disable iff (clk)
        exp_sram_oe |-> sram_addr == exp_sram_addr)
        else mismatch("sram_addr", 32'($sampled(sram_addr)), 32'($sampled(exp_sram_addr)));

    initial begin
        clk         = 1'b1;
        addr        = '0;
        d_from_cpu  = '0;
        wr          = 1'b0;
        cs          = 1'b0;
        mapper_kind = kind_ascii8;
        rom_size    = 25'h0080000;
        sram_size   = 2'd2;
        repeat (3) @(posedge reset);
        clk <= 1'b0;

        // Out of reset every window shows bank 0
        read_windows();
        repeat (6) begin
            write_banks(8'h40);
            read_windows();
        end
        sram_sequence(kind_ascii8, 8'h40, 2'd2);
        sram_sequence(kind_koei, 8'h40, 2'd1);
        sram_sequence(kind_wizardry, 8'h80, 2'd0);

        set_config(kind_ascii16, 2'd2);
        repeat (4) begin
            write_banks(8'h00);
            read_windows();
        end
        // 0x20 is one past the last 16 kB bank of a 512 kB ROM
        bus_cycle(16'h7000, 8'h20, 1'b1);
        bus_cycle(16'h6000, 8'h20, 1'b1);
        wait_sram_oe(16'h9abc);
        bus_cycle(16'hb7ff, 8'h5a, 1'b1);
        read_windows();
        set_config(kind_ascii16, `CART_SRAM_NONE);
        bus_cycle(16'h8765, 8'h11, 1'b1);
        read_windows();
        set_config(kind_ascii16, 2'd0);
        read_windows();

        // Writes under one mapper kind leave the other mapper's banks alone
        set_config(kind_ascii8, 2'd1);
        write_banks(8'h40);
        set_config(kind_ascii16, 2'd2);
        write_banks(8'h00);
        set_config(kind_ascii8, 2'd1);
        read_windows();
        set_config(kind_ascii16, 2'd2);
        read_windows();
        set_config(kind_ascii8, 2'd2);
        @(posedge reset);

        if (!seen_we) begin
            $display("sram_we never went high during the SRAM sequences");
            $display("=== FAIL ===");
            $fatal(1, "SRAM write path not reached");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cart_top.sv
/* Cartridge slot top level. Address outputs follow addr with no latency, and a
   register write takes effect at the clock edge where it is sampled */
`timescale 1ns/1ns
`default_nettype none

module cart_top (
    input  wire                         reset,
    input  wire                         clk,
    input  wire msx_bus_pkg::cpu_addr_t addr,
    input  wire msx_bus_pkg::cpu_data_t d_from_cpu,
    input  wire                         wr,
    input  wire                         cs,
    input  wire cart_pkg::mapper_kind_t mapper_kind,
    input  wire cart_pkg::rom_addr_t    rom_size,
    input  wire cart_pkg::sram_size_t   sram_size,
    output cart_pkg::rom_addr_t         mem_addr,
    output logic                        mem_oe,
    output cart_pkg::sram_addr_t        sram_addr,
    output logic                        sram_oe,
    output logic                        sram_we
);
    import cart_pkg::*;

    logic       cs_a8;
    logic       cs_a16;
    logic       koei;
    logic       wizardry;
    rom_addr_t  a8_mem_addr;
    rom_addr_t  a16_mem_addr;
    sram_addr_t a8_sram_addr;
    sram_addr_t a16_sram_addr;
    logic       a8_sram_oe;
    logic       a16_sram_oe;

    cart_ctrl u_ctrl (
        .reset         (reset),
        .clk           (clk),
        .cs            (cs),
        .wr            (wr),
        .mapper_kind   (mapper_kind),
        .sram_size     (sram_size),
        .a8_mem_addr   (a8_mem_addr),
        .a16_mem_addr  (a16_mem_addr),
        .a8_sram_addr  (a8_sram_addr),
        .a16_sram_addr (a16_sram_addr),
        .a8_sram_oe    (a8_sram_oe),
        .a16_sram_oe   (a16_sram_oe),
        .cs_a8         (cs_a8),
        .cs_a16        (cs_a16),
        .koei          (koei),
        .wizardry      (wizardry),
        .mem_addr      (mem_addr),
        .mem_oe        (mem_oe),
        .sram_addr     (sram_addr),
        .sram_oe       (sram_oe),
        .sram_we       (sram_we)
    );

    cart_ascii8 u_ascii8 (
        .reset      (reset),
        .clk        (clk),
        .rom_size   (rom_size),
        .addr       (addr),
        .d_from_cpu (d_from_cpu),
        .wr         (wr),
        .cs         (cs_a8),
        .koei       (koei),
        .wizardry   (wizardry),
        .mem_addr   (a8_mem_addr),
        .sram_addr  (a8_sram_addr),
        .sram_oe    (a8_sram_oe)
    );

    cart_ascii16 u_ascii16 (
        .reset      (reset),
        .clk        (clk),
        .rom_size   (rom_size),
        .addr       (addr),
        .d_from_cpu (d_from_cpu),
        .wr         (wr),
        .cs         (cs_a16),
        .mem_addr   (a16_mem_addr),
        .sram_addr  (a16_sram_addr),
        .sram_oe    (a16_sram_oe)
    );

endmodule

`default_nettype wire

// File: hdl/cart_ascii16.sv
/* ASCII16 mapper with a single 2 kB SRAM mirrored over a 16 kB window. rom_size
   must be a power of two of at least 32 kB */
`timescale 1ns/1ns
`default_nettype none

module cart_ascii16 (
    input  wire                         reset,
    input  wire                         clk,
    input  wire cart_pkg::rom_addr_t    rom_size,
    input  wire msx_bus_pkg::cpu_addr_t addr,
    input  wire msx_bus_pkg::cpu_data_t d_from_cpu,
    input  wire                         wr,
    input  wire                         cs,
    output cart_pkg::rom_addr_t         mem_addr,
    output cart_pkg::sram_addr_t        sram_addr,
    output logic                        sram_oe
);
    import cart_pkg::*;

    bank_t      rom_bank [0:1];
    logic [1:0] sram_en;

    logic  bank_wr;
    logic  wr_sel;
    logic  rd_sel;
    logic  in_window;
    bank_t rom_mask;

    // Bank 0 at 0x6000-0x67FF, bank 1 at 0x7000-0x77FF
    assign bank_wr = cs && wr && (addr[15:13] == 3'b011) && !addr[11];
    assign wr_sel  = addr[12];

    assign rom_mask = rom_size[21:14] - 8'd1;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            rom_bank[0] <= '0;
            rom_bank[1] <= '0;
            sram_en     <= '0;
        end else if (bank_wr) begin
            // A bank number one past the ROM end selects the SRAM
            if (d_from_cpu == rom_size[21:14]) begin
                sram_en[wr_sel] <= 1'b1;
            end else begin
                sram_en[wr_sel]  <= 1'b0;
                rom_bank[wr_sel] <= d_from_cpu;
            end
        end
    end

    // Outside 0x4000-0xBFFF the ROM mirrors the opposite bank
    assign in_window = addr[15] ^ addr[14];
    assign rd_sel    = in_window ? addr[15] : ~addr[15];
    assign mem_addr  = {3'b000, rom_bank[rd_sel] & rom_mask, addr[13:0]};

    assign sram_oe   = cs && in_window && sram_en[rd_sel];
    assign sram_addr = {4'h0, addr[10:0]};

    a_sram_window: assert property (@(posedge reset) disable iff (clk)
        sram_oe |-> (addr[15:14] == 2'b01 || addr[15:14] == 2'b10))
        else $error("ASCII16 SRAM selected outside 0x4000-0xBFFF");

endmodule

`default_nettype wire

// File: hdl/cart_ascii8.sv
/* ASCII8 mapper with the Koei and Wizardry variants. rom_size must be a power
   of two of at least 16 kB; only bits 1:0 of an SRAM bank reach the address */
`timescale 1ns/1ns
`default_nettype none

module cart_ascii8 (
    input  wire                         reset,
    input  wire                         clk,
    input  wire cart_pkg::rom_addr_t    rom_size,
    input  wire msx_bus_pkg::cpu_addr_t addr,
    input  wire msx_bus_pkg::cpu_data_t d_from_cpu,
    input  wire                         wr,
    input  wire                         cs,
    input  wire                         koei,
    input  wire                         wizardry,
    output cart_pkg::rom_addr_t         mem_addr,
    output cart_pkg::sram_addr_t        sram_addr,
    output logic                        sram_oe
);
    import cart_pkg::*;

    bank_t      rom_bank [0:3];
    bank_t      sram_bank [0:7];
    logic [7:0] sram_en;

    logic       reg_wr;
    logic [1:0] region;
    logic [2:0] page;
    logic [7:0] page_bit;
    logic [7:0] page_allow;
    bank_t      rom_mask;
    bank_t      en_bit;
    logic [1:0] bank_num;
    bank_t      sram_base;

    // Registers sit at 0x6000, 0x6800, 0x7000 and 0x7800
    assign reg_wr = cs && wr && (addr[15:13] == 3'b011);
    assign region = addr[12:11];

    // Register n controls the 8 kB page n + 2 of the CPU map
    assign page     = {1'b0, region} + 3'd2;
    assign page_bit = 8'd1 << page;

    // Koei can also map SRAM into page 2 (0x4000)
    assign page_allow = koei ? 8'h34 : 8'h30;

    // ROM size in 8 kB units doubles as the SRAM enable bit
    assign rom_mask = rom_size[20:13] - 8'd1;
    assign en_bit   = wizardry ? 8'h80 : rom_size[20:13];

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < 4; i++) begin
                rom_bank[i] <= '0;
            end
            for (int i = 0; i < 8; i++) begin
                sram_bank[i] <= '0;
            end
            sram_en <= '0;
        end else if (reg_wr) begin
            if ((d_from_cpu & en_bit) != 8'h00) begin
                sram_en         <= sram_en | (page_bit & page_allow);
                // The enable bit itself is not part of the SRAM bank number
                sram_bank[page] <= d_from_cpu & ~en_bit;
            end else begin
                sram_en          <= sram_en & ~page_bit;
                rom_bank[region] <= d_from_cpu;
            end
        end
    end

    // 0x0000 mirrors banks 2/3 and 0xC000 mirrors banks 0/1
    assign bank_num = {(addr[15] ^ addr[14]) ? addr[15] : ~addr[15], addr[13]};
    assign mem_addr = {4'h0, rom_bank[bank_num] & rom_mask, addr[12:0]};

    assign sram_base = sram_bank[addr[15:13]];
    assign sram_oe   = cs && sram_en[addr[15:13]];
    assign sram_addr = {sram_base[1:0], addr[12:0]};

    // The variant flags come from the mapper kind decode in cart_ctrl
    a_one_variant: assert property (@(posedge reset) disable iff (clk)
        !(koei && wizardry))
        else $error("koei and wizardry selected together");

endmodule

`default_nettype wire

// File: hdl/cart_ctrl.sv
/* Mapper selection and output merge. mapper_kind and sram_size must be held
   stable while the CPU runs; the clock port is reset and the reset port is clk */
`timescale 1ns/1ns
`default_nettype none
`include "cart_cfg.svh"

module cart_ctrl (
    input  wire                           reset,
    input  wire                           clk,
    input  wire                           cs,
    input  wire                           wr,
    input  wire cart_pkg::mapper_kind_t   mapper_kind,
    input  wire cart_pkg::sram_size_t     sram_size,
    input  wire cart_pkg::rom_addr_t      a8_mem_addr,
    input  wire cart_pkg::rom_addr_t      a16_mem_addr,
    input  wire cart_pkg::sram_addr_t     a8_sram_addr,
    input  wire cart_pkg::sram_addr_t     a16_sram_addr,
    input  wire                           a8_sram_oe,
    input  wire                           a16_sram_oe,
    output logic                          cs_a8,
    output logic                          cs_a16,
    output logic                          koei,
    output logic                          wizardry,
    output cart_pkg::rom_addr_t           mem_addr,
    output logic                          mem_oe,
    output cart_pkg::sram_addr_t          sram_addr,
    output logic                          sram_oe,
    output logic                          sram_we
);
    import cart_pkg::*;

    logic       is_a16;
    logic       sram_fitted;
    sram_addr_t size_mask;

    // Only one mapper gets the chip select, so the idle one never sees a write
    assign is_a16   = (mapper_kind == kind_ascii16);
    assign koei     = (mapper_kind == kind_koei);
    assign wizardry = (mapper_kind == kind_wizardry);
    assign cs_a8    = cs && !is_a16;
    assign cs_a16   = cs && is_a16;

    assign mem_addr = is_a16 ? a16_mem_addr : a8_mem_addr;
    assign mem_oe   = cs;

    // A cartridge without SRAM gets neither reads nor writes on the SRAM side
    assign sram_fitted = (sram_size != `CART_SRAM_NONE);
    assign sram_oe     = sram_fitted && (is_a16 ? a16_sram_oe : a8_sram_oe);
    assign sram_we     = sram_oe && wr;

    // Upper SRAM address bits beyond the fitted size are forced to zero
    always_comb begin
        case (sram_size)
            2'd0:    size_mask = 15'h07ff;
            2'd1:    size_mask = 15'h1fff;
            2'd2:    size_mask = 15'h7fff;
            default: size_mask = '0;
        endcase
    end

    assign sram_addr = (is_a16 ? a16_sram_addr : a8_sram_addr) & size_mask;

    a_one_mapper: assert property (@(posedge reset) disable iff (clk)
        !(cs_a8 && cs_a16))
        else $error("both mappers selected at once");

endmodule

`default_nettype wire

// File: hdl/cart_pkg.sv
/* Cartridge side types. Widths come from cart_cfg.svh, so the include path
   must point at include/ */
`default_nettype none
`include "cart_cfg.svh"

package cart_pkg;

    // Koei and Wizardry are ASCII8 variants and share its datapath
    typedef enum logic [1:0] {
        kind_ascii8   = 2'd0,
        kind_koei     = 2'd1,
        kind_wizardry = 2'd2,
        kind_ascii16  = 2'd3
    } mapper_kind_t;

    typedef logic [`CART_BANK_W-1:0] bank_t;
    typedef logic [`CART_ROM_AW-1:0] rom_addr_t;
    typedef logic [`CART_SRAM_AW-1:0] sram_addr_t;

    // 0 is 2 kB, 1 is 8 kB, 2 is 32 kB, 3 means no SRAM fitted
    typedef logic [1:0] sram_size_t;

endpackage

`default_nettype wire

// File: hdl/msx_bus_pkg.sv
/* CPU side of the cartridge slot. Plain Z80 address and data, no wait states */
`default_nettype none

package msx_bus_pkg;

    // Full 64 kB CPU address space as seen by the slot
    typedef logic [15:0] cpu_addr_t;

    typedef logic [7:0] cpu_data_t;

endpackage

`default_nettype wire

// File: include/cart_cfg.svh
/* Widths for the cartridge datapath. ROM addresses reach 32 MB; the battery SRAM
   is 32 kB at most, and the bank registers hold one CPU byte */
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// Byte address toward the cartridge ROM
`define CART_ROM_AW 25

// Byte address toward the battery SRAM
`define CART_SRAM_AW 15

// One mapper bank register
`define CART_BANK_W 8

// SRAM size code for a cartridge without SRAM
`define CART_SRAM_NONE 2'd3

`endif
